/* compile.f */
+incdir+src
src/utils_pkg.sv
src/axi_if.sv
src/axi_wr_channel.sv
src/axi_rd_channel.sv
src/axi_mem_wrapper.sv
src/axi_mem_top.sv
test/tb_axi_mem.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the AXI memory testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f compile.f \
  --top-module tb_axi_mem \
  --Mdir obj_dir -o tb_axi_mem

./obj_dir/tb_axi_mem | tee sim.log

if grep -q "RESULT: PASS" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

/* src/axi_if.sv */
`include "axi_mem_defs.svh"

interface axi_if import utils_pkg::*; #(
  parameter int ID_WIDTH = `AXI_DEF_ID_WIDTH
)();

  // write address
  logic [ID_WIDTH-1:0] awid;
  axi_addr_t           awaddr;
  axi_len_t            awlen;
  axi_burst_t          awburst;
  logic                awvalid;
  logic                awready;

  // write data
  axi_data_t           wdata;
  axi_strb_t           wstrb;
  logic                wlast;
  logic                wvalid;
  logic                wready;

  // write response
  logic [ID_WIDTH-1:0] bid;
  axi_resp_t           bresp;
  logic                bvalid;
  logic                bready;

  // read address
  logic [ID_WIDTH-1:0] arid;
  axi_addr_t           araddr;
  axi_len_t            arlen;
  axi_burst_t          arburst;
  logic                arvalid;
  logic                arready;

  // read data
  logic [ID_WIDTH-1:0] rid;
  axi_data_t           rdata;
  axi_resp_t           rresp;
  logic                rlast;
  logic                rvalid;
  logic                rready;

  modport master (
    output awid, awaddr, awlen, awburst, awvalid, input awready,
    output wdata, wstrb, wlast, wvalid, input wready,
    input  bid, bresp, bvalid, output bready,
    output arid, araddr, arlen, arburst, arvalid, input arready,
    input  rid, rdata, rresp, rlast, rvalid, output rready
  );

  modport slave (
    input  awid, awaddr, awlen, awburst, awvalid, output awready,
    input  wdata, wstrb, wlast, wvalid, output wready,
    output bid, bresp, bvalid, input bready,
    input  arid, araddr, arlen, arburst, arvalid, output arready,
    output rid, rdata, rresp, rlast, rvalid, input rready
  );

endinterface

/* src/axi_mem_defs.svh */
`ifndef AXI_MEM_DEFS_SVH
`define AXI_MEM_DEFS_SVH

// bus widths
`define AXI_DATA_WIDTH   32
`define AXI_ADDR_WIDTH   32
`define AXI_STRB_WIDTH   (`AXI_DATA_WIDTH / 8)
`define AXI_LEN_WIDTH    8

// default sizes
`define AXI_DEF_MEM_KB   4
`define AXI_DEF_ID_WIDTH 8

// burst codes
`define AXI_BURST_FIXED  2'd0
`define AXI_BURST_INCR   2'd1
`define AXI_BURST_WRAP   2'd2

// response codes
`define AXI_RESP_OKAY    2'd0
`define AXI_RESP_SLVERR  2'd2

`endif

/* src/axi_mem_top.sv */
`include "axi_mem_defs.svh"

module axi_mem_top import utils_pkg::*; #(
  parameter int MEM_KB   = `AXI_DEF_MEM_KB,
  parameter int ID_WIDTH = `AXI_DEF_ID_WIDTH
)(
  input  logic                clk,
  input  logic                rst_n,
  input  logic [ID_WIDTH-1:0] awid,
  input  axi_addr_t           awaddr,
  input  axi_len_t            awlen,
  input  axi_burst_t          awburst,
  input  logic                awvalid,
  output logic                awready,
  input  axi_data_t           wdata,
  input  axi_strb_t           wstrb,
  input  logic                wlast,
  input  logic                wvalid,
  output logic                wready,
  output logic [ID_WIDTH-1:0] bid,
  output axi_resp_t           bresp,
  output logic                bvalid,
  input  logic                bready,
  input  logic [ID_WIDTH-1:0] arid,
  input  axi_addr_t           araddr,
  input  axi_len_t            arlen,
  input  axi_burst_t          arburst,
  input  logic                arvalid,
  output logic                arready,
  output logic [ID_WIDTH-1:0] rid,
  output axi_data_t           rdata,
  output axi_resp_t           rresp,
  output logic                rlast,
  output logic                rvalid,
  input  logic                rready
);

  axi_if #(.ID_WIDTH(ID_WIDTH)) bus ();

  // master side in
  assign bus.awid    = awid;
  assign bus.awaddr  = awaddr;
  assign bus.awlen   = awlen;
  assign bus.awburst = awburst;
  assign bus.awvalid = awvalid;
  assign bus.wdata   = wdata;
  assign bus.wstrb   = wstrb;
  assign bus.wlast   = wlast;
  assign bus.wvalid  = wvalid;
  assign bus.bready  = bready;
  assign bus.arid    = arid;
  assign bus.araddr  = araddr;
  assign bus.arlen   = arlen;
  assign bus.arburst = arburst;
  assign bus.arvalid = arvalid;
  assign bus.rready  = rready;

  // slave side out
  assign awready = bus.awready;
  assign wready  = bus.wready;
  assign bid     = bus.bid;
  assign bresp   = bus.bresp;
  assign bvalid  = bus.bvalid;
  assign arready = bus.arready;
  assign rid     = bus.rid;
  assign rdata   = bus.rdata;
  assign rresp   = bus.rresp;
  assign rlast   = bus.rlast;
  assign rvalid  = bus.rvalid;

  axi_mem_wrapper #(
    .MEM_KB   (MEM_KB),
    .ID_WIDTH (ID_WIDTH)
  ) u_mem (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (bus)
  );

endmodule

/* src/axi_mem_wrapper.sv */
`include "axi_mem_defs.svh"

module axi_mem_wrapper import utils_pkg::*; #(
  parameter int MEM_KB   = `AXI_DEF_MEM_KB,
  parameter int ID_WIDTH = `AXI_DEF_ID_WIDTH
)(
  input  logic clk,
  input  logic rst_n,
  axi_if.slave bus
);

  localparam int WORDS = MEM_KB * 256;
  localparam int IDX_W = $clog2(WORDS);

  logic                       wr_req;
  logic [`AXI_ADDR_WIDTH-3:0] wr_idx;
  axi_data_t                  wr_data;
  axi_strb_t                  wr_strb;
  logic                       rd_req;
  logic [`AXI_ADDR_WIDTH-3:0] rd_idx;
  logic                       rd_gnt;
  axi_data_t                  rd_q;

  axi_data_t mem [WORDS];

  axi_wr_channel #(
    .ID_WIDTH (ID_WIDTH)
  ) u_wr (
    .clk     (clk),
    .rst_n   (rst_n),
    .bus     (bus),
    .wr_req  (wr_req),
    .wr_idx  (wr_idx),
    .wr_data (wr_data),
    .wr_strb (wr_strb)
  );

  axi_rd_channel #(
    .ID_WIDTH (ID_WIDTH)
  ) u_rd (
    .clk     (clk),
    .rst_n   (rst_n),
    .bus     (bus),
    .rd_req  (rd_req),
    .rd_idx  (rd_idx),
    .rd_gnt  (rd_gnt),
    .rd_data (rd_q)
  );

  // single port, writes win
  assign rd_gnt = rd_req && !wr_req;

  // upper index bits drop, so addresses wrap around the array
  always_ff @(posedge clk) begin
    if (wr_req) begin
      for (int b = 0; b < `AXI_STRB_WIDTH; b++) begin
        if (wr_strb[b]) mem[wr_idx[IDX_W-1:0]][8*b +: 8] <= wr_data[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_gnt) rd_q <= mem[rd_idx[IDX_W-1:0]];  // only moves on a grant
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    !(wr_req && rd_gnt));

endmodule

/* src/axi_rd_channel.sv */
`include "axi_mem_defs.svh"

module axi_rd_channel import utils_pkg::*; #(
  parameter int ID_WIDTH = `AXI_DEF_ID_WIDTH
)(
  input  logic                       clk,
  input  logic                       rst_n,
  axi_if.slave                       bus,
  output logic                       rd_req,
  output logic [`AXI_ADDR_WIDTH-3:0] rd_idx,
  input  logic                       rd_gnt,
  input  axi_data_t                  rd_data
);

  rd_state_t                  state;
  logic [ID_WIDTH-1:0]        id_q;
  logic [`AXI_ADDR_WIDTH-3:0] idx_q;
  axi_len_t                   cnt_q;     // fetches left after the next one
  logic                       incr_q;
  logic                       err_q;
  logic                       last_q;
  logic                       pend_q;    // more beats to fetch
  logic                       rvalid_q;
  logic                       ar_hs;
  logic                       r_hs;
  logic                       slot_free;
  logic                       issue;
  logic                       bad_burst;

  assign ar_hs = bus.arvalid && bus.arready;
  assign r_hs  = bus.rvalid && bus.rready;

  assign bad_burst = (bus.arburst != `AXI_BURST_FIXED) &&
                     (bus.arburst != `AXI_BURST_INCR);

  // held beat leaves this cycle or there is none
  assign slot_free = !rvalid_q || bus.rready;

  // error bursts never touch memory
  assign rd_req = (state == RD_BEAT) && pend_q && slot_free && !err_q;
  assign issue  = (state == RD_BEAT) && pend_q && slot_free && (err_q || rd_gnt);
  assign rd_idx = idx_q;

  assign bus.arready = (state == RD_IDLE);
  assign bus.rvalid  = rvalid_q;
  assign bus.rid     = id_q;
  assign bus.rlast   = last_q;
  assign bus.rresp   = err_q ? `AXI_RESP_SLVERR : `AXI_RESP_OKAY;
  assign bus.rdata   = err_q ? '0 : rd_data;  // RAM output stays put until next grant

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= RD_IDLE;
      pend_q   <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      case (state)
        RD_IDLE: begin
          if (ar_hs) begin
            state  <= RD_BEAT;
            pend_q <= 1'b1;
          end
        end
        RD_BEAT: begin
          if (issue && cnt_q == '0) pend_q <= 1'b0;
          if (r_hs && bus.rlast) state <= RD_IDLE;
        end
        default: state <= RD_IDLE;
      endcase
      if (issue) begin
        rvalid_q <= 1'b1;
      end else if (r_hs) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ar_hs) begin
      id_q   <= bus.arid;
      idx_q  <= bus.araddr[`AXI_ADDR_WIDTH-1:2];
      cnt_q  <= bus.arlen;
      incr_q <= (bus.arburst == `AXI_BURST_INCR);
      err_q  <= bad_burst;
    end else if (issue) begin
      last_q <= (cnt_q == '0);
      if (cnt_q != '0) cnt_q <= cnt_q - 1'b1;
      if (incr_q) idx_q <= idx_q + 1'b1;
    end
  end

  // beat under back-pressure is held as is
  assert property (@(posedge clk) disable iff (!rst_n)
    bus.rvalid && !bus.rready |=> bus.rvalid && $stable(bus.rdata) &&
      $stable(bus.rlast) && $stable(bus.rid) && $stable(bus.rresp));

endmodule

/* src/axi_wr_channel.sv */
`include "axi_mem_defs.svh"

module axi_wr_channel import utils_pkg::*; #(
  parameter int ID_WIDTH = `AXI_DEF_ID_WIDTH
)(
  input  logic                       clk,
  input  logic                       rst_n,
  axi_if.slave                       bus,
  output logic                       wr_req,
  output logic [`AXI_ADDR_WIDTH-3:0] wr_idx,
  output axi_data_t                  wr_data,
  output axi_strb_t                  wr_strb
);

  wr_state_t                  state;
  logic [ID_WIDTH-1:0]        id_q;
  logic [`AXI_ADDR_WIDTH-3:0] idx_q;   // current word index
  axi_len_t                   cnt_q;   // beats left after this one
  logic                       incr_q;
  logic                       err_q;
  logic                       aw_hs;
  logic                       w_hs;
  logic                       b_hs;
  logic                       bad_burst;

  assign aw_hs = bus.awvalid && bus.awready;
  assign w_hs  = bus.wvalid && bus.wready;
  assign b_hs  = bus.bvalid && bus.bready;

  // only FIXED and INCR are served
  assign bad_burst = (bus.awburst != `AXI_BURST_FIXED) &&
                     (bus.awburst != `AXI_BURST_INCR);

  assign bus.awready = (state == WR_IDLE);
  assign bus.wready  = (state == WR_DATA);
  assign bus.bvalid  = (state == WR_RESP);
  assign bus.bid     = id_q;
  assign bus.bresp   = err_q ? `AXI_RESP_SLVERR : `AXI_RESP_OKAY;

  // memory write request, same cycle as the W beat
  assign wr_req  = w_hs && !err_q;
  assign wr_idx  = idx_q;
  assign wr_data = bus.wdata;
  assign wr_strb = bus.wstrb;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= WR_IDLE;
    end else begin
      case (state)
        WR_IDLE: begin
          if (aw_hs) state <= WR_DATA;
        end
        WR_DATA: begin
          if (w_hs && bus.wlast) state <= WR_RESP;
        end
        WR_RESP: begin
          if (b_hs) state <= WR_IDLE;
        end
        default: state <= WR_IDLE;
      endcase
    end
  end

  // burst context
  always_ff @(posedge clk) begin
    if (aw_hs) begin
      id_q   <= bus.awid;
      idx_q  <= bus.awaddr[`AXI_ADDR_WIDTH-1:2];
      cnt_q  <= bus.awlen;
      incr_q <= (bus.awburst == `AXI_BURST_INCR);
      err_q  <= bad_burst;
    end else if (w_hs) begin
      if (incr_q) idx_q <= idx_q + 1'b1;  // FIXED keeps the start word
      if (cnt_q != '0) cnt_q <= cnt_q - 1'b1;
    end
  end

  // B must not drop or change before the master takes it
  assert property (@(posedge clk) disable iff (!rst_n)
    bus.bvalid && !bus.bready |=> bus.bvalid && $stable(bus.bid) && $stable(bus.bresp));

  assert property (@(posedge clk) disable iff (!rst_n)
    wr_req |-> state == WR_DATA);

  // wlast from the master agrees with the awlen it announced
  assert property (@(posedge clk) disable iff (!rst_n)
    w_hs |-> bus.wlast == (cnt_q == '0));

endmodule

/* src/utils_pkg.sv */
`include "axi_mem_defs.svh"

package utils_pkg;

  // bus fields
  typedef logic [`AXI_ADDR_WIDTH-1:0] axi_addr_t;  // byte address
  typedef logic [`AXI_DATA_WIDTH-1:0] axi_data_t;
  typedef logic [`AXI_STRB_WIDTH-1:0] axi_strb_t;  // one bit per byte lane
  typedef logic [`AXI_LEN_WIDTH-1:0]  axi_len_t;   // beats minus one
  typedef logic [1:0]                 axi_burst_t;
  typedef logic [1:0]                 axi_resp_t;

  // write engine
  typedef enum logic [1:0] {
    WR_IDLE,  // waiting for AW
    WR_DATA,  // taking W beats
    WR_RESP   // holding B
  } wr_state_t;

  // read engine
  typedef enum logic {
    RD_IDLE,  // waiting for AR
    RD_BEAT   // fetching and returning R beats
  } rd_state_t;

endpackage

/* test/tb_axi_mem.sv */
`include "axi_mem_defs.svh"

module tb_axi_mem import utils_pkg::*;;

  localparam int REF_WORDS  = 1024;   // 4 KB default
  localparam int MAX_CYCLES = 20000;

  logic                          clk = 1'b0;
  logic                          rst_n;
  logic [`AXI_DEF_ID_WIDTH-1:0]  awid, bid, arid, rid;
  axi_addr_t                     awaddr, araddr;
  axi_len_t                      awlen, arlen;
  axi_burst_t                    awburst, arburst;
  logic                          awvalid, awready, wlast, wvalid, wready;
  logic                          bvalid, bready, arvalid, arready, rlast, rvalid, rready;
  axi_data_t                     wdata, rdata;
  axi_strb_t                     wstrb;
  axi_resp_t                     bresp, rresp;

  axi_data_t                     ref_mem [REF_WORDS];
  axi_data_t                     exp_rdata [$];
  axi_resp_t                     exp_rresp [$];
  logic                          exp_rlast [$];
  logic [`AXI_DEF_ID_WIDTH-1:0]  exp_rid [$];
  axi_resp_t                     exp_bresp [$];
  logic [`AXI_DEF_ID_WIDTH-1:0]  exp_bid [$];
  int                            errors = 0;
  int                            checks = 0;
  int                            seed = 48;
  int                            cycles = 0;
  string                         test_name = "reset";

  axi_mem_top dut (
    .clk (clk), .rst_n (rst_n),
    .awid (awid), .awaddr (awaddr), .awlen (awlen), .awburst (awburst),
    .awvalid (awvalid), .awready (awready),
    .wdata (wdata), .wstrb (wstrb), .wlast (wlast), .wvalid (wvalid), .wready (wready),
    .bid (bid), .bresp (bresp), .bvalid (bvalid), .bready (bready),
    .arid (arid), .araddr (araddr), .arlen (arlen), .arburst (arburst),
    .arvalid (arvalid), .arready (arready),
    .rid (rid), .rdata (rdata), .rresp (rresp), .rlast (rlast), .rvalid (rvalid),
    .rready (rready)
  );

  always #2 clk = ~clk;

  function automatic bit is_served(axi_burst_t burst);
    return (burst == `AXI_BURST_FIXED) || (burst == `AXI_BURST_INCR);
  endfunction

  // word touched by a given beat
  function automatic int beat_idx(axi_burst_t burst, int start, int beat);
    if (burst == `AXI_BURST_INCR) return (start + beat) % REF_WORDS;
    return start % REF_WORDS;
  endfunction

  function automatic void ref_write(axi_burst_t burst, int idx, axi_data_t data,
                                    axi_strb_t strb);
    if (!is_served(burst)) return;  // error bursts leave memory alone
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) ref_mem[idx][8*b +: 8] = data[8*b +: 8];
    end
  endfunction

  function automatic axi_data_t ref_read(int idx);
    return ref_mem[idx % REF_WORDS];
  endfunction

  function automatic axi_data_t fill_word(int idx);
    return (axi_data_t'(idx) * 32'h9e37_79b1) ^ 32'h0f0f_a5a5;
  endfunction

  function automatic int rand_gap();
    return {$random(seed)} % 3;
  endfunction

  // mode 0 fill pattern, 1 random data, 2 random data and strobes
  task automatic write_burst(input logic [`AXI_DEF_ID_WIDTH-1:0] id, input int start,
                             input int len, input axi_burst_t burst, input int mode);
    axi_data_t data;
    axi_strb_t strb;
    int        gap;
    exp_bid.push_back(id);
    exp_bresp.push_back(is_served(burst) ? `AXI_RESP_OKAY : `AXI_RESP_SLVERR);
    repeat (rand_gap()) @(posedge clk);
    awid    <= id;
    awaddr  <= axi_addr_t'(start * 4);
    awlen   <= axi_len_t'(len);
    awburst <= burst;
    awvalid <= 1'b1;
    @(negedge clk);
    while (!awready) @(negedge clk);
    @(posedge clk);
    awvalid <= 1'b0;
    for (int beat = 0; beat <= len; beat++) begin
      gap = rand_gap();
      if (gap != 0) begin
        wvalid <= 1'b0;
        repeat (gap) @(posedge clk);
      end
      data   = (mode == 0) ? fill_word(start + beat) : $random(seed);
      strb   = (mode == 2) ? axi_strb_t'($random(seed)) : 4'hf;
      wdata  <= data;
      wstrb  <= strb;
      wlast  <= (beat == len);
      wvalid <= 1'b1;
      @(negedge clk);
      while (!wready) @(negedge clk);
      @(posedge clk);
      ref_write(burst, beat_idx(burst, start, beat), data, strb);
    end
    wvalid <= 1'b0;
    wlast  <= 1'b0;
    repeat (rand_gap()) @(posedge clk);
    bready <= 1'b1;
    @(negedge clk);
    while (!bvalid) @(negedge clk);
    @(posedge clk);
    bready <= 1'b0;
  endtask

  task automatic read_burst(input logic [`AXI_DEF_ID_WIDTH-1:0] id, input int start,
                            input int len, input axi_burst_t burst);
    int got;
    int gap;
    for (int beat = 0; beat <= len; beat++) begin
      exp_rdata.push_back(is_served(burst) ? ref_read(beat_idx(burst, start, beat)) : '0);
      exp_rresp.push_back(is_served(burst) ? `AXI_RESP_OKAY : `AXI_RESP_SLVERR);
      exp_rlast.push_back(beat == len);
      exp_rid.push_back(id);
    end
    repeat (rand_gap()) @(posedge clk);
    arid    <= id;
    araddr  <= axi_addr_t'(start * 4);
    arlen   <= axi_len_t'(len);
    arburst <= burst;
    arvalid <= 1'b1;
    @(negedge clk);
    while (!arready) @(negedge clk);
    @(posedge clk);
    arvalid <= 1'b0;
    got = 0;
    while (got <= len) begin
      gap = rand_gap();
      if (gap != 0) begin
        rready <= 1'b0;  // back-pressure
        repeat (gap) @(posedge clk);
      end
      rready <= 1'b1;
      @(negedge clk);
      while (!rvalid) @(negedge clk);
      @(posedge clk);
      got++;
    end
    rready <= 1'b0;
  endtask

  // inputs only move on rising edges, so the falling edge sees the coming handshake
  always @(negedge clk) begin
    if (rst_n && rvalid && rready) begin
      if (exp_rdata.size() == 0) begin
        errors++;
        $display("%s: extra R beat with no outstanding read", test_name);
      end else begin
        checks++;
        if (rdata !== exp_rdata[0]) begin
          errors++;
          $display("FAIL %s rdata exp=%h act=%h", test_name, exp_rdata[0], rdata);
        end
        if (rresp !== exp_rresp[0]) begin
          errors++;
          $display("FAIL %s rresp exp=%0d act=%0d", test_name, exp_rresp[0], rresp);
        end
        if (rid !== exp_rid[0]) begin
          errors++;
          $display("FAIL %s rid exp=%h act=%h", test_name, exp_rid[0], rid);
        end
        if (exp_rlast[0] && rlast !== 1'b1) begin
          errors++;
          $display("%s: rlast missing on the last beat of a read", test_name);
        end
        if (!exp_rlast[0] && rlast !== 1'b0) begin
          errors++;
          $display("%s: rlast raised before the last beat of a read", test_name);
        end
        exp_rdata.delete(0);
        exp_rresp.delete(0);
        exp_rlast.delete(0);
        exp_rid.delete(0);
      end
    end
    if (rst_n && bvalid && bready) begin
      if (exp_bid.size() == 0) begin
        errors++;
        $display("%s: B response with no outstanding write", test_name);
      end else begin
        checks++;
        if (bresp !== exp_bresp[0]) begin
          errors++;
          $display("FAIL %s bresp exp=%0d act=%0d", test_name, exp_bresp[0], bresp);
        end
        if (bid !== exp_bid[0]) begin
          errors++;
          $display("FAIL %s bid exp=%h act=%h", test_name, exp_bid[0], bid);
        end
        exp_bid.delete(0);
        exp_bresp.delete(0);
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES) begin
      $display("timeout after %0d cycles in %s", cycles, test_name);
      $display("errors: %0d, checks: %0d", errors + 1, checks);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    int         w_start;
    int         r_start;
    int         w_len;
    int         r_len;
    axi_burst_t w_burst;
    axi_burst_t r_burst;
    rst_n   <= 1'b0;
    awid    <= '0;
    awaddr  <= '0;
    awlen   <= '0;
    awburst <= '0;
    awvalid <= 1'b0;
    wdata   <= '0;
    wstrb   <= '0;
    wlast   <= 1'b0;
    wvalid  <= 1'b0;
    bready  <= 1'b0;
    arid    <= '0;
    araddr  <= '0;
    arlen   <= '0;
    arburst <= '0;
    arvalid <= 1'b0;
    rready  <= 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    test_name = "fill";  // words 0..127 get a known value
    write_burst(8'h01, 0, 127, `AXI_BURST_INCR, 0);
    test_name = "single";
    write_burst(8'h11, 5, 0, `AXI_BURST_INCR, 1);
    read_burst(8'h22, 5, 0, `AXI_BURST_INCR);
    test_name = "incr16";
    write_burst(8'h33, 16, 15, `AXI_BURST_INCR, 2);
    read_burst(8'h34, 16, 15, `AXI_BURST_INCR);
    test_name = "fixed4";
    write_burst(8'h44, 40, 3, `AXI_BURST_FIXED, 2);
    read_burst(8'h45, 40, 3, `AXI_BURST_FIXED);
    read_burst(8'h46, 38, 4, `AXI_BURST_INCR);  // neighbours untouched
    test_name = "wrap";
    write_burst(8'h55, 8, 3, `AXI_BURST_WRAP, 1);
    read_burst(8'h56, 8, 3, `AXI_BURST_WRAP);
    read_burst(8'h57, 8, 3, `AXI_BURST_INCR);

    test_name = "overlap";
    for (int i = 0; i < 24; i++) begin
      w_len   = {$random(seed)} % 16;
      r_len   = {$random(seed)} % 16;
      w_start = {$random(seed)} % 48;
      r_start = 64 + {$random(seed)} % 48;
      if (i % 2 == 1) begin  // swap halves so both regions see writes
        w_start = w_start + 64;
        r_start = r_start - 64;
      end
      w_burst = ($random(seed) & 1) ? `AXI_BURST_INCR : `AXI_BURST_FIXED;
      r_burst = ($random(seed) & 1) ? `AXI_BURST_INCR : `AXI_BURST_FIXED;
      fork
        write_burst(8'(i), w_start, w_len, w_burst, 2);
        read_burst(8'(i) | 8'h80, r_start, r_len, r_burst);
      join
    end

    // both engines back in idle with no stray beat or response
    repeat (4) @(negedge clk);
    if (rvalid || bvalid || wready || !awready || !arready) begin
      errors++;
      $display("DUT not idle at the end: rvalid=%b bvalid=%b wready=%b awready=%b arready=%b",
               rvalid, bvalid, wready, awready, arready);
    end
    $display("errors: %0d, checks: %0d", errors, checks);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
